/* verilog/mem_map_pkg.sv */
// SDRAM memory map definitions
// Address and word widths, lane types, CPU work-RAM region
package mem_map_pkg;

    ////////////////////////////////////////
    // SDRAM port geometry
    ////////////////////////////////////////

    localparam int SDR_ADDR_W = 25;
    localparam int SDR_DATA_W = 16;

    // Byte address, word and byte-lane enables
    typedef logic [SDR_ADDR_W-1:0] sdr_addr_t;
    typedef logic [SDR_DATA_W-1:0] sdr_word_t;
    // Bit 1 selects the high byte
    typedef logic [1:0]            sdr_be_t;

    ////////////////////////////////////////
    // Regions
    ////////////////////////////////////////

    // CPU work RAM, upper nine bits prefix every high-score access
    localparam sdr_addr_t CPU_RAM_BASE = 25'h1F0_0000;

    // High-score port address, low 16 bits land in SDRAM
    localparam int HS_ADDR_W = 20;

endpackage

/* verilog/ioctl_pkg.sv */
// Download stream definitions
// Index codes, ioctl widths and DIP bank size
package ioctl_pkg;

    localparam int IOCTL_ADDR_W = 25;

    typedef logic [7:0] ioctl_byte_t;

    // Download index codes
    localparam logic [7:0] IDX_ROM = 8'd0;
    localparam logic [7:0] IDX_DIP = 8'd254;

    // DIP storage and the part of it that leaves the core
    localparam int DIP_BYTES     = 8;
    localparam int DIP_OUT_BYTES = 3;

endpackage

/* verilog/ch3_arbiter.sv */
// Fixed-priority arbiter for the shared SDRAM channel
// ROM download first, then high score, then CPU
module ch3_arbiter
    import mem_map_pkg::*;
(
    input  logic      clk_sys,
    input  logic      rst_n,
    input  logic      dl_active,
    input  logic      rom_req,
    input  sdr_addr_t rom_addr,
    input  sdr_word_t rom_din,
    input  sdr_be_t   rom_be,
    input  logic      hs_req,
    input  sdr_addr_t hs_addr,
    input  sdr_word_t hs_din,
    input  sdr_be_t   hs_be,
    input  logic      cpu_req,
    input  sdr_addr_t cpu_addr,
    input  sdr_word_t cpu_din,
    input  sdr_be_t   cpu_be,
    input  logic      sdr_rdy,
    output logic      rom_rdy,
    output logic      hs_rdy,
    output logic      cpu_rdy,
    output logic      sdr_req,
    output sdr_addr_t sdr_addr,
    output sdr_word_t sdr_din,
    output sdr_be_t   sdr_be,
    output logic      sdr_rnw
);

    typedef enum logic [1:0] {ST_IDLE, ST_ISSUE, ST_WAIT} state_t;
    typedef enum logic [1:0] {GNT_ROM, GNT_HS, GNT_CPU} grant_t;

    state_t state;
    grant_t grant;
    logic   rom_pend;
    logic   hs_pend;
    logic   cpu_pend;
    logic   done;

    assign done    = (state == ST_WAIT) && sdr_rdy;
    assign rom_rdy = done && (grant == GNT_ROM);
    assign hs_rdy  = done && (grant == GNT_HS);
    assign cpu_rdy = done && (grant == GNT_CPU);
    assign sdr_req = (state == ST_ISSUE);

    // Request pulses are held here until their access completes
    always_ff @(posedge clk_sys) begin
        if (!rst_n) begin
            rom_pend <= 1'b0;
            hs_pend  <= 1'b0;
            cpu_pend <= 1'b0;
        end else begin
            if (rom_req)
                rom_pend <= 1'b1;
            else if (rom_rdy)
                rom_pend <= 1'b0;
            if (hs_req)
                hs_pend <= 1'b1;
            else if (hs_rdy)
                hs_pend <= 1'b0;
            if (cpu_req)
                cpu_pend <= 1'b1;
            else if (cpu_rdy)
                cpu_pend <= 1'b0;
        end
    end

    ////////////////////////////////////////
    // Grant FSM
    ////////////////////////////////////////

    always_ff @(posedge clk_sys) begin
        if (!rst_n) begin
            state <= ST_IDLE;
            grant <= GNT_ROM;
        end else begin
            case (state)
                ST_IDLE: begin
                    // Download owns the channel until it ends
                    if (rom_pend) begin
                        grant <= GNT_ROM;
                        state <= ST_ISSUE;
                    end else if (!dl_active && hs_pend) begin
                        grant <= GNT_HS;
                        state <= ST_ISSUE;
                    end else if (!dl_active && cpu_pend) begin
                        grant <= GNT_CPU;
                        state <= ST_ISSUE;
                    end
                end
                ST_ISSUE: state <= ST_WAIT;
                ST_WAIT: begin
                    if (sdr_rdy)
                        state <= ST_IDLE;
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    // Granted client fields go straight to the SDRAM port
    always_comb begin
        case (grant)
            GNT_ROM: begin
                sdr_addr = rom_addr;
                sdr_din  = rom_din;
                sdr_be   = rom_be;
            end
            GNT_HS: begin
                sdr_addr = hs_addr;
                sdr_din  = hs_din;
                sdr_be   = hs_be;
            end
            default: begin
                sdr_addr = cpu_addr;
                sdr_din  = cpu_din;
                sdr_be   = cpu_be;
            end
        endcase
    end

    // No lane enabled means a read
    assign sdr_rnw = ~|sdr_be;

endmodule

/* verilog/rom_download_counter.sv */
// ROM download byte counter
// Turns the ioctl byte stream into addressed SDRAM byte writes
module rom_download_counter
    import mem_map_pkg::*;
    import ioctl_pkg::*;
(
    input  logic        clk_sys,
    input  logic        rst_n,
    input  logic        ioctl_download,
    input  logic [7:0]  ioctl_index,
    input  logic        ioctl_wr,
    input  ioctl_byte_t ioctl_dout,
    input  logic        rom_rdy,
    output logic        ioctl_wait,
    output logic        dl_active,
    output logic        rom_req,
    output sdr_addr_t   rom_addr,
    output sdr_word_t   rom_din,
    output sdr_be_t     rom_be
);

    logic      dl_rom;
    logic      dl_start;
    logic      rom_wr;
    logic      wait_q;
    sdr_addr_t byte_cnt;
    sdr_addr_t cur_cnt;

    assign dl_rom   = ioctl_download && (ioctl_index == IDX_ROM);
    assign dl_start = dl_rom && !dl_active;
    assign rom_wr   = ioctl_wr && dl_rom;

    // Count restarts at zero with each new download
    assign cur_cnt = dl_start ? '0 : byte_cnt;

    // Stream is released in the cycle the write completes
    assign ioctl_wait = wait_q && !rom_rdy;

    always_ff @(posedge clk_sys) begin
        if (!rst_n) begin
            dl_active <= 1'b0;
            rom_req   <= 1'b0;
            wait_q    <= 1'b0;
            byte_cnt  <= '0;
        end else begin
            dl_active <= dl_rom;
            rom_req   <= rom_wr;
            if (rom_wr)
                wait_q <= 1'b1;
            else if (rom_rdy)
                wait_q <= 1'b0;
            if (rom_wr)
                byte_cnt <= cur_cnt + 1'b1;
            else if (dl_start)
                byte_cnt <= '0;
        end
    end

    // Byte on both lanes, odd addresses take the high lane
    always_ff @(posedge clk_sys) begin
        if (rom_wr) begin
            rom_addr <= cur_cnt;
            rom_din  <= {ioctl_dout, ioctl_dout};
            rom_be   <= cur_cnt[0] ? 2'b10 : 2'b01;
        end
    end

endmodule

/* verilog/hiscore_bridge.sv */
// High-score byte port into the CPU work-RAM region
// Edge-detected requests, byte extraction on read return
module hiscore_bridge
    import mem_map_pkg::*;
    import ioctl_pkg::*;
(
    input  logic                 clk_sys,
    input  logic                 rst_n,
    input  logic [HS_ADDR_W-1:0] hs_address,
    input  ioctl_byte_t          hs_data_in,
    input  logic                 hs_read,
    input  logic                 hs_write,
    input  logic                 hs_rdy,
    input  sdr_word_t            sdr_dout,
    output logic                 hs_req,
    output sdr_addr_t            hs_addr,
    output sdr_word_t            hs_din,
    output sdr_be_t              hs_be,
    output ioctl_byte_t          hs_data_out,
    output logic                 hs_data_ready
);

    logic rd_q;
    logic wr_q;
    logic active;
    logic start;

    // New access only on a rising edge and with nothing in flight
    assign start = !active && ((hs_write && !wr_q) || (hs_read && !rd_q));

    always_ff @(posedge clk_sys) begin
        if (!rst_n) begin
            rd_q          <= 1'b0;
            wr_q          <= 1'b0;
            active        <= 1'b0;
            hs_req        <= 1'b0;
            hs_data_ready <= 1'b0;
        end else begin
            rd_q          <= hs_read;
            wr_q          <= hs_write;
            hs_req        <= start;
            hs_data_ready <= active && hs_rdy;
            if (start)
                active <= 1'b1;
            else if (hs_rdy)
                active <= 1'b0;
        end
    end

    ////////////////////////////////////////
    // Request fields and read data
    ////////////////////////////////////////

    always_ff @(posedge clk_sys) begin
        if (start) begin
            hs_addr <= {CPU_RAM_BASE[SDR_ADDR_W-1:16], hs_address[15:0]};
            hs_din  <= {hs_data_in, hs_data_in};
            // Read leaves both lanes off
            hs_be   <= hs_write ? {hs_address[0], ~hs_address[0]} : 2'b00;
        end
        if (active && hs_rdy)
            hs_data_out <= hs_addr[0] ? sdr_dout[15:8] : sdr_dout[7:0];
    end

endmodule

/* verilog/dip_switch_bank.sv */
// DIP switch register file loaded from the download stream
module dip_switch_bank
    import ioctl_pkg::*;
(
    input  logic                       clk_sys,
    input  logic                       rst_n,
    input  logic                       ioctl_wr,
    input  logic [7:0]                 ioctl_index,
    input  logic [IOCTL_ADDR_W-1:0]    ioctl_addr,
    input  ioctl_byte_t                ioctl_dout,
    output logic [DIP_OUT_BYTES*8-1:0] dip_sw
);

    ioctl_byte_t dip_mem [DIP_BYTES];

    always_ff @(posedge clk_sys) begin
        if (!rst_n) begin
            for (int i = 0; i < DIP_BYTES; i++)
                dip_mem[i] <= '0;
        end else if (ioctl_wr && (ioctl_index == IDX_DIP) &&
                     (ioctl_addr < IOCTL_ADDR_W'(DIP_BYTES))) begin
            dip_mem[ioctl_addr[$clog2(DIP_BYTES)-1:0]] <= ioctl_dout;
        end
    end

    // Byte 0 in the low bits
    always_comb begin
        for (int i = 0; i < DIP_OUT_BYTES; i++)
            dip_sw[i*8 +: 8] = dip_mem[i];
    end

endmodule

/* verilog/ch3_mux_top.sv */
// Shared SDRAM channel request side
// ROM download, high score and CPU clients behind one arbiter, DIP bank
module ch3_mux_top
    import mem_map_pkg::*;
    import ioctl_pkg::*;
(
    input  logic                       clk_sys,
    input  logic                       rst_n,
    input  logic                       ioctl_download,
    input  logic [7:0]                 ioctl_index,
    input  logic                       ioctl_wr,
    input  logic [IOCTL_ADDR_W-1:0]    ioctl_addr,
    input  ioctl_byte_t                ioctl_dout,
    input  logic [HS_ADDR_W-1:0]       hs_address,
    input  ioctl_byte_t                hs_data_in,
    input  logic                       hs_read,
    input  logic                       hs_write,
    input  logic                       cpu_req,
    input  sdr_addr_t                  cpu_addr,
    input  sdr_word_t                  cpu_din,
    input  sdr_be_t                    cpu_be,
    input  logic                       sdr_rdy,
    input  sdr_word_t                  sdr_dout,
    output logic                       ioctl_wait,
    output ioctl_byte_t                hs_data_out,
    output logic                       hs_data_ready,
    output logic                       cpu_rdy,
    output sdr_word_t                  cpu_dout,
    output logic [DIP_OUT_BYTES*8-1:0] dip_sw,
    output logic                       sdr_req,
    output sdr_addr_t                  sdr_addr,
    output sdr_word_t                  sdr_din,
    output sdr_be_t                    sdr_be,
    output logic                       sdr_rnw
);

    logic      dl_active;
    logic      rom_req;
    logic      rom_rdy;
    sdr_addr_t rom_addr;
    sdr_word_t rom_din;
    sdr_be_t   rom_be;
    logic      hs_req;
    logic      hs_rdy;
    sdr_addr_t hs_addr;
    sdr_word_t hs_din;
    sdr_be_t   hs_be;

    // CPU reads straight off the shared read bus
    assign cpu_dout = sdr_dout;

    ////////////////////////////////////////
    // Clients
    ////////////////////////////////////////

    rom_download_counter u_rom_dl (
        .clk_sys        (clk_sys),
        .rst_n          (rst_n),
        .ioctl_download (ioctl_download),
        .ioctl_index    (ioctl_index),
        .ioctl_wr       (ioctl_wr),
        .ioctl_dout     (ioctl_dout),
        .rom_rdy        (rom_rdy),
        .ioctl_wait     (ioctl_wait),
        .dl_active      (dl_active),
        .rom_req        (rom_req),
        .rom_addr       (rom_addr),
        .rom_din        (rom_din),
        .rom_be         (rom_be)
    );

    hiscore_bridge u_hiscore (
        .clk_sys       (clk_sys),
        .rst_n         (rst_n),
        .hs_address    (hs_address),
        .hs_data_in    (hs_data_in),
        .hs_read       (hs_read),
        .hs_write      (hs_write),
        .hs_rdy        (hs_rdy),
        .sdr_dout      (sdr_dout),
        .hs_req        (hs_req),
        .hs_addr       (hs_addr),
        .hs_din        (hs_din),
        .hs_be         (hs_be),
        .hs_data_out   (hs_data_out),
        .hs_data_ready (hs_data_ready)
    );

    dip_switch_bank u_dip (
        .clk_sys     (clk_sys),
        .rst_n       (rst_n),
        .ioctl_wr    (ioctl_wr),
        .ioctl_index (ioctl_index),
        .ioctl_addr  (ioctl_addr),
        .ioctl_dout  (ioctl_dout),
        .dip_sw      (dip_sw)
    );

    ////////////////////////////////////////
    // Channel arbitration
    ////////////////////////////////////////

    ch3_arbiter u_arb (
        .clk_sys   (clk_sys),
        .rst_n     (rst_n),
        .dl_active (dl_active),
        .rom_req   (rom_req),
        .rom_addr  (rom_addr),
        .rom_din   (rom_din),
        .rom_be    (rom_be),
        .hs_req    (hs_req),
        .hs_addr   (hs_addr),
        .hs_din    (hs_din),
        .hs_be     (hs_be),
        .cpu_req   (cpu_req),
        .cpu_addr  (cpu_addr),
        .cpu_din   (cpu_din),
        .cpu_be    (cpu_be),
        .sdr_rdy   (sdr_rdy),
        .rom_rdy   (rom_rdy),
        .hs_rdy    (hs_rdy),
        .cpu_rdy   (cpu_rdy),
        .sdr_req   (sdr_req),
        .sdr_addr  (sdr_addr),
        .sdr_din   (sdr_din),
        .sdr_be    (sdr_be),
        .sdr_rnw   (sdr_rnw)
    );

endmodule

/* tests/sdram_model.sv */
// Behavioral SDRAM for the testbench
// Byte-addressed memory, random latency, byte-lane writes
module sdram_model
    import mem_map_pkg::*;
(
    input  logic      clk_sys,
    input  logic      rst_n,
    input  logic      sdr_req,
    input  sdr_addr_t sdr_addr,
    input  sdr_word_t sdr_din,
    input  sdr_be_t   sdr_be,
    input  logic      sdr_rnw,
    output logic      sdr_rdy,
    output sdr_word_t sdr_dout
);

    logic [7:0]  mem [sdr_addr_t];
    sdr_addr_t   addr_q;
    sdr_word_t   din_q;
    sdr_be_t     be_q;
    logic        rnw_q;
    logic        busy;
    int unsigned cnt;

    // Unwritten locations read back a pattern of the whole address
    function automatic logic [7:0] read_byte(input sdr_addr_t a);
        if (mem.exists(a))
            return mem[a];
        return a[7:0] ^ a[15:8] ^ a[23:16] ^ {7'b0, a[24]};
    endfunction

    always @(posedge clk_sys) begin
        if (!rst_n) begin
            busy     <= 1'b0;
            sdr_rdy  <= 1'b0;
            sdr_dout <= '0;
        end else begin
            sdr_rdy <= 1'b0;
            if (sdr_req && !busy) begin
                addr_q <= sdr_addr;
                din_q  <= sdr_din;
                be_q   <= sdr_be;
                rnw_q  <= sdr_rnw;
                // Ready lands 2 to 9 cycles after the request cycle
                cnt    <= $urandom_range(9, 2) - 1;
                busy   <= 1'b1;
            end else if (busy) begin
                if (cnt <= 1) begin
                    busy    <= 1'b0;
                    sdr_rdy <= 1'b1;
                    if (rnw_q) begin
                        sdr_dout <= {read_byte({addr_q[24:1], 1'b1}),
                                     read_byte({addr_q[24:1], 1'b0})};
                    end else begin
                        if (be_q[0])
                            mem[{addr_q[24:1], 1'b0}] = din_q[7:0];
                        if (be_q[1])
                            mem[{addr_q[24:1], 1'b1}] = din_q[15:8];
                    end
                end else begin
                    cnt <= cnt - 1;
                end
            end
        end
    end

endmodule

/* tests/tb_ch3_mux.sv */
// Testbench for the shared SDRAM channel top level
// Clock, reset, client stimulus, assertions and timeout
module tb_ch3_mux
    import mem_map_pkg::*;
    import ioctl_pkg::*;
();

    localparam int TIMEOUT_CYCLES = 4000;
    localparam int ROM_LEN        = 32;

    logic                       clk_sys = 1'b0;
    logic                       rst_n;
    logic                       ioctl_download;
    logic [7:0]                 ioctl_index;
    logic                       ioctl_wr;
    logic [IOCTL_ADDR_W-1:0]    ioctl_addr;
    ioctl_byte_t                ioctl_dout;
    logic [HS_ADDR_W-1:0]       hs_address;
    ioctl_byte_t                hs_data_in;
    logic                       hs_read;
    logic                       hs_write;
    logic                       cpu_req;
    sdr_addr_t                  cpu_addr;
    sdr_word_t                  cpu_din;
    sdr_be_t                    cpu_be;
    logic                       sdr_rdy;
    sdr_word_t                  sdr_dout;
    logic                       ioctl_wait;
    ioctl_byte_t                hs_data_out;
    logic                       hs_data_ready;
    logic                       cpu_rdy;
    sdr_word_t                  cpu_dout;
    logic [DIP_OUT_BYTES*8-1:0] dip_sw;
    logic                       sdr_req;
    sdr_addr_t                  sdr_addr;
    sdr_word_t                  sdr_din;
    sdr_be_t                    sdr_be;
    logic                       sdr_rnw;

    ioctl_byte_t rom_bytes [ROM_LEN];
    int          rom_seen    = 0;
    logic        rom_out     = 1'b0;
    logic        outstanding = 1'b0;
    int          cycles      = 0;

    always #5 clk_sys = ~clk_sys;

    ch3_mux_top UUT (.*);

    sdram_model u_sdram (
        .clk_sys  (clk_sys),
        .rst_n    (rst_n),
        .sdr_req  (sdr_req),
        .sdr_addr (sdr_addr),
        .sdr_din  (sdr_din),
        .sdr_be   (sdr_be),
        .sdr_rnw  (sdr_rnw),
        .sdr_rdy  (sdr_rdy),
        .sdr_dout (sdr_dout)
    );

    task automatic fail_now(input string msg);
        $display("%s", msg);
        $display("Result: FAILED");
        $fatal(1, "stopping at first error");
    endtask

    ////////////////////////////////////////
    // Checks
    ////////////////////////////////////////

    a_reset: assert property (@(posedge clk_sys) !rst_n |=>
        (!sdr_req && !cpu_rdy && !ioctl_wait && !hs_data_ready && dip_sw == '0))
        else fail_now($sformatf(
            "Error: reset sdr_req=%h cpu_rdy=%h ioctl_wait=%h hs_data_ready=%h dip_sw=%h",
            sdr_req, cpu_rdy, ioctl_wait, hs_data_ready, dip_sw));

    a_single: assert property (@(posedge clk_sys) disable iff (!rst_n)
        sdr_req |-> !outstanding)
        else fail_now($sformatf("Error: sdr_req=%h with outstanding=%h", sdr_req, outstanding));

    // During a download only ROM writes reach the channel
    a_dl_prio: assert property (@(posedge clk_sys) disable iff (!rst_n)
        ioctl_download |-> (!cpu_rdy && !(sdr_req && sdr_rnw)))
        else fail_now($sformatf("Error: cpu_rdy=%h sdr_rnw=%h during download", cpu_rdy, sdr_rnw));

    always @(posedge clk_sys) begin
        if (rst_n) begin
            if (sdr_req && ioctl_download) begin
                assert (sdr_addr == sdr_addr_t'(rom_seen))
                    else fail_now($sformatf("Error: sdr_addr %h expected %h", sdr_addr, rom_seen));
                assert (sdr_be == (rom_seen[0] ? 2'b10 : 2'b01))
                    else fail_now($sformatf("Error: sdr_be %h at byte %h", sdr_be, rom_seen));
                assert (sdr_din == {rom_bytes[rom_seen], rom_bytes[rom_seen]})
                    else fail_now($sformatf("Error: sdr_din %h expected %h", sdr_din,
                        {rom_bytes[rom_seen], rom_bytes[rom_seen]}));
                rom_seen <= rom_seen + 1;
            end
            // Stream held from the cycle after the write until its ready
            assert (ioctl_wait == (rom_out && !sdr_rdy))
                else fail_now($sformatf("Error: ioctl_wait %h expected %h", ioctl_wait,
                    rom_out && !sdr_rdy));
            if (ioctl_wr && ioctl_download && ioctl_index == IDX_ROM)
                rom_out <= 1'b1;
            else if (sdr_rdy)
                rom_out <= 1'b0;
            if (sdr_req)
                outstanding <= 1'b1;
            else if (sdr_rdy)
                outstanding <= 1'b0;
        end
    end

    always @(posedge clk_sys) begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("Timeout: tests did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("Result: FAILED");
            $fatal(1, "timeout");
        end
    end

    ////////////////////////////////////////
    // Client drivers
    ////////////////////////////////////////

    task automatic cpu_access(input sdr_addr_t a, input sdr_word_t d, input sdr_be_t be,
                              output sdr_word_t q);
        cpu_addr <= a;
        cpu_din  <= d;
        cpu_be   <= be;
        cpu_req  <= 1'b1;
        @(posedge clk_sys);
        cpu_req <= 1'b0;
        while (!cpu_rdy)
            @(posedge clk_sys);
        q = cpu_dout;
    endtask

    task automatic hs_access(input logic is_write, input logic [HS_ADDR_W-1:0] a,
                             input ioctl_byte_t d, input logic check_req);
        sdr_addr_t exp_addr;
        sdr_be_t   exp_be;
        exp_addr = CPU_RAM_BASE + sdr_addr_t'(a[15:0]);
        exp_be   = is_write ? (a[0] ? 2'b10 : 2'b01) : 2'b00;
        hs_address <= a;
        hs_data_in <= d;
        if (is_write)
            hs_write <= 1'b1;
        else
            hs_read <= 1'b1;
        @(posedge clk_sys);
        hs_write <= 1'b0;
        hs_read  <= 1'b0;
        if (check_req) begin
            while (!sdr_req)
                @(posedge clk_sys);
            assert (sdr_addr == exp_addr)
                else fail_now($sformatf("Error: sdr_addr %h expected %h", sdr_addr, exp_addr));
            assert (sdr_be == exp_be)
                else fail_now($sformatf("Error: sdr_be %h expected %h", sdr_be, exp_be));
            assert (sdr_rnw == !is_write)
                else fail_now($sformatf("Error: sdr_rnw %h expected %h", sdr_rnw, !is_write));
            assert (!is_write || sdr_din == {d, d})
                else fail_now($sformatf("Error: sdr_din %h expected %h", sdr_din, {d, d}));
        end
        while (!hs_data_ready)
            @(posedge clk_sys);
        assert (is_write || hs_data_out == d)
            else fail_now($sformatf("Error: hs_data_out %h expected %h", hs_data_out, d));
    endtask

    task automatic dip_write(input logic [7:0] idx, input int a, input ioctl_byte_t d,
                             input logic [23:0] exp);
        ioctl_index <= idx;
        ioctl_addr  <= IOCTL_ADDR_W'(a);
        ioctl_dout  <= d;
        ioctl_wr    <= 1'b1;
        @(posedge clk_sys);
        ioctl_wr <= 1'b0;
        @(posedge clk_sys);
        assert (dip_sw == exp)
            else fail_now($sformatf("Error: dip_sw %h expected %h", dip_sw, exp));
    endtask

    task automatic rom_download();
        sdr_word_t q;
        ioctl_download <= 1'b1;
        ioctl_index    <= IDX_ROM;
        fork
            begin
                // CPU read of bytes 4 and 5 waits out the download
                cpu_access(25'd4, 16'h0000, 2'b00, q);
                assert (q == {rom_bytes[5], rom_bytes[4]})
                    else fail_now($sformatf("Error: cpu_dout %h expected %h", q,
                        {rom_bytes[5], rom_bytes[4]}));
            end
            begin
                for (int i = 0; i < ROM_LEN; i++) begin
                    ioctl_wr   <= 1'b1;
                    ioctl_addr <= IOCTL_ADDR_W'(i);
                    ioctl_dout <= rom_bytes[i];
                    @(posedge clk_sys);
                    ioctl_wr <= 1'b0;
                    @(posedge clk_sys);
                    while (ioctl_wait)
                        @(posedge clk_sys);
                end
                ioctl_download <= 1'b0;
            end
        join
        assert (rom_seen == ROM_LEN)
            else fail_now($sformatf("Error: rom writes %h expected %h", rom_seen, ROM_LEN));
    endtask

    task automatic mixed_traffic();
        sdr_word_t   words [6];
        ioctl_byte_t bytes [6];
        sdr_word_t   q;
        for (int i = 0; i < 6; i++) begin
            words[i] = sdr_word_t'($urandom);
            bytes[i] = ioctl_byte_t'($urandom);
            fork
                cpu_access(sdr_addr_t'(25'h100 + 4 * i), words[i], 2'b11, q);
                hs_access(1'b1, HS_ADDR_W'(20'h200 + i), bytes[i], 1'b0);
            join
        end
        for (int i = 0; i < 6; i++) begin
            cpu_access(sdr_addr_t'(25'h100 + 4 * i), 16'h0000, 2'b00, q);
            assert (q == words[i])
                else fail_now($sformatf("Error: cpu_dout %h expected %h", q, words[i]));
            hs_access(1'b0, HS_ADDR_W'(20'h200 + i), bytes[i], 1'b1);
        end
    endtask

    initial begin
        void'($urandom(32'he8c8));
        rst_n          = 1'b0;
        ioctl_download = 1'b0;
        ioctl_index    = 8'd0;
        ioctl_wr       = 1'b0;
        ioctl_addr     = '0;
        ioctl_dout     = '0;
        hs_address     = '0;
        hs_data_in     = '0;
        hs_read        = 1'b0;
        hs_write       = 1'b0;
        cpu_req        = 1'b0;
        cpu_addr       = '0;
        cpu_din        = '0;
        cpu_be         = '0;
        for (int i = 0; i < ROM_LEN; i++)
            rom_bytes[i] = ioctl_byte_t'($urandom);
        repeat (8) @(posedge clk_sys);
        rst_n <= 1'b1;
        repeat (2) @(posedge clk_sys);

        rom_download();
        hs_access(1'b1, 20'h00123, 8'ha5, 1'b1);
        hs_access(1'b0, 20'h00123, 8'ha5, 1'b1);

        dip_write(IDX_DIP, 0, 8'h11, 24'h000011);
        dip_write(IDX_DIP, 1, 8'h22, 24'h002211);
        dip_write(IDX_DIP, 2, 8'h33, 24'h332211);
        dip_write(IDX_DIP, 9, 8'h44, 24'h332211);
        dip_write(8'd5, 1, 8'h55, 24'h332211);

        mixed_traffic();
        repeat (4) @(posedge clk_sys);
        $display("Result: PASSED");
        $finish;
    end

endmodule

/* vlog.f */
verilog/mem_map_pkg.sv
verilog/ioctl_pkg.sv
verilog/ch3_arbiter.sv
verilog/rom_download_counter.sv
verilog/hiscore_bridge.sv
verilog/dip_switch_bank.sv
verilog/ch3_mux_top.sv
tests/sdram_model.sv
tests/tb_ch3_mux.sv

/* Makefile */
# Verilator build for the shared SDRAM channel testbench

VERILATOR ?= verilator
TOP       ?= tb_ch3_mux
FILELIST  ?= vlog.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

SIM_BIN = $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)

run: $(SIM_BIN)
	-./$(SIM_BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "Result: FAILED" $(LOG); then \
		echo "Simulation failed, see $(LOG)"; exit 1; \
	fi
	@grep -q "Result: PASSED" $(LOG) || { echo "No result in $(LOG)"; exit 1; }

clean:
	rm -rf $(OBJ_DIR) $(LOG)
